// ==== hdl/fe_pipe_pkg.sv ====
`default_nettype none

package fe_pipe_pkg;

	import rv_isa_pkg::*;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [31:0]     instr;
	} fetch_pkt_t;

	// the instruction memory port follows a four-phase req/ack handshake.
	typedef struct packed {
		logic            req;
		logic [XLEN-1:0] addr;
	} imem_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] data;
	} imem_rsp_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] target;
	} redirect_t;

	typedef struct packed {
		logic            en;
		logic [4:0]      addr;
		logic [XLEN-1:0] data;
	} rf_write_t;

	typedef struct packed {
		decoded_t        dec;
		logic [XLEN-1:0] op_a;
		logic [XLEN-1:0] op_b;
	} issue_pkt_t;

endpackage

`default_nettype wire

// ==== hdl/instr_decode.sv ====
`default_nettype none

module instr_decode
	import rv_isa_pkg::*, fe_pipe_pkg::*;
(
	input  wire             clk,
	input  wire             rst,
	input  wire             in_valid,
	output logic            in_ready,
	input  wire fetch_pkt_t in_pkt,
	output logic            out_valid,
	input  wire             out_ready,
	output decoded_t        out_dec,
	output redirect_t       redirect
);

	logic [31:0]     ins;
	logic [6:0]      opcode;
	logic [2:0]      func3;
	logic            i_type;
	logic            u_type;
	logic            j_type;
	logic            b_type;
	logic            s_type;
	logic            r_type;
	logic [XLEN-1:0] imm;
	logic            fire;
	logic            redir_valid;
	logic [XLEN-1:0] redir_target;

	assign ins    = in_pkt.instr;
	assign opcode = ins[6:0];
	assign func3  = ins[14:12];

	assign i_type = (opcode == OPC_JALR) || (opcode == OPC_LOAD) || (opcode == OPC_OP_IMM)
		|| (opcode == OPC_OP_IMM_32) || (opcode == OPC_SYSTEM);
	assign u_type = (opcode == OPC_LUI) || (opcode == OPC_AUIPC);
	assign j_type = (opcode == OPC_JAL);
	assign b_type = (opcode == OPC_BRANCH);
	assign s_type = (opcode == OPC_STORE);
	assign r_type = (opcode == OPC_OP) || (opcode == OPC_OP_32);

	always_comb begin
		if (i_type) begin
			imm = {{52{ins[31]}}, ins[31:20]};
		end else if (u_type) begin
			imm = {{32{ins[31]}}, ins[31:12], 12'b0};
		end else if (j_type) begin
			imm = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		end else if (b_type) begin
			imm = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		end else if (s_type) begin
			imm = {{52{ins[31]}}, ins[31:25], ins[11:7]};
		end else begin
			imm = '0;
		end
	end

	always_comb begin
		out_dec.pc        = in_pkt.pc;
		out_dec.opcode    = opcode;
		out_dec.func3     = func3;
		out_dec.func7_b30 = ins[30];
		out_dec.rs1       = u_type ? 5'd0 : ins[19:15];
		out_dec.rs2       = (i_type || u_type) ? 5'd0 : ins[24:20];
		out_dec.rd        = (s_type || b_type) ? 5'd0 : ins[11:7];
		out_dec.imm       = imm;

		if (j_type || opcode == OPC_AUIPC) begin
			out_dec.v1_src = V1_PC;
		end else if (opcode == OPC_SYSTEM && func3[2] && func3[1:0] != 2'b00) begin
			out_dec.v1_src = V1_ZIMM;
		end else begin
			out_dec.v1_src = V1_RS1;
		end
		out_dec.v2_src = (r_type || b_type) ? V2_RS2 : V2_IMM;

		// M extension sits in the op space with funct7 = 1.
		out_dec.mul_en  = r_type && ins[25] && !func3[2];
		out_dec.div_en  = r_type && ins[25] && func3[2];
		out_dec.fence_i = (opcode == OPC_MISC_MEM) && func3[0];

		case (opcode)
			OPC_OP_32:     out_dec.word_mode = WORD_REG;
			OPC_OP_IMM_32: out_dec.word_mode = WORD_IMM;
			default:       out_dec.word_mode = WORD_NONE;
		endcase

		if (opcode == OPC_LOAD) begin
			out_dec.mem_mode = MEM_LOAD;
		end else if (s_type) begin
			out_dec.mem_mode = MEM_STORE;
		end else begin
			out_dec.mem_mode = MEM_IDLE;
		end

		if (opcode == OPC_JALR) begin
			out_dec.jump_mode = JMP_JALR;
		end else if (j_type) begin
			out_dec.jump_mode = JMP_JAL;
		end else if (b_type) begin
			out_dec.jump_mode = JMP_BRANCH;
		end else begin
			out_dec.jump_mode = JMP_IDLE;
		end
	end

	// while redirect is up, the input is the fall-through and is swallowed.
	assign out_valid = in_valid && !redir_valid;
	assign in_ready  = out_ready || redir_valid;
	assign fire      = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			redir_valid <= 1'b0;
		end else begin
			redir_valid <= fire && j_type;
		end
	end

	always_ff @(posedge clk) begin
		if (fire && j_type) begin
			redir_target <= in_pkt.pc + imm;
		end
	end

	assign redirect = '{valid: redir_valid, target: redir_target};

endmodule

`default_nettype wire

// ==== hdl/instr_fetch.sv ====
`default_nettype none

module instr_fetch
	import rv_isa_pkg::*, fe_pipe_pkg::*;
#(
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  wire            clk,
	input  wire            rst,
	output imem_req_t      imem_req,
	input  wire imem_rsp_t imem_rsp,
	input  wire redirect_t redirect,
	output logic           pkt_valid,
	input  wire            pkt_ready,
	output fetch_pkt_t     pkt
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT_ACK,
		S_WAIT_REL,
		S_HOLD
	} state_t;

	state_t          state;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc_next;
	logic [XLEN-1:0] req_addr;
	logic            held;
	logic            held_next;
	logic            discard;
	logic            push;
	logic            start_req;

	// a held packet is the fall-through of a jal once redirect shows up.
	assign pkt_valid = held && !redirect.valid;
	assign push      = pkt_valid && pkt_ready;
	assign held_next = held && !push && !redirect.valid;

	always_comb begin
		pc_next = pc;
		if (redirect.valid) begin
			pc_next = redirect.target;
		end else if (push) begin
			pc_next = pc + XLEN'(4);
		end
	end

	always_comb begin
		case (state)
			S_IDLE:     start_req = 1'b1;
			S_WAIT_REL: start_req = !imem_rsp.ack && !held_next;
			S_HOLD:     start_req = !held_next;
			default:    start_req = 1'b0;
		endcase
	end

	assign imem_req = '{req: (state == S_WAIT_ACK), addr: req_addr};

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= S_IDLE;
			pc      <= RESET_PC;
			held    <= 1'b0;
			discard <= 1'b0;
		end else begin
			pc   <= pc_next;
			held <= held_next;
			if (redirect.valid && state == S_WAIT_ACK) begin
				discard <= 1'b1;
			end
			if (start_req) begin
				state <= S_WAIT_ACK;
			end else if (state == S_WAIT_ACK && imem_rsp.ack) begin
				// the data of a stale request is thrown away here.
				state   <= S_WAIT_REL;
				held    <= !(discard || redirect.valid);
				discard <= 1'b0;
			end else if (state == S_WAIT_REL && !imem_rsp.ack) begin
				state <= S_HOLD;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_req) begin
			req_addr <= pc_next;
		end
		if (state == S_WAIT_ACK && imem_rsp.ack) begin
			pkt <= '{pc: req_addr, instr: imem_rsp.data};
		end
	end

	req_held_until_ack: assert property (
		@(posedge clk) disable iff (rst)
		imem_req.req && !imem_rsp.ack |=> imem_req.req && $stable(imem_req.addr)
	);

endmodule

`default_nettype wire

// ==== hdl/operand_issue.sv ====
`default_nettype none

module operand_issue
	import rv_isa_pkg::*, fe_pipe_pkg::*;
(
	input  wire             clk,
	input  wire             rst,
	input  wire             in_valid,
	output logic            in_ready,
	input  wire decoded_t   in_dec,
	output logic            out_valid,
	input  wire             out_ready,
	output issue_pkt_t      out_pkt,
	output logic [4:0]      rf_rs1,
	output logic [4:0]      rf_rs2,
	input  wire [XLEN-1:0]  rf_rd1,
	input  wire [XLEN-1:0]  rf_rd2
);

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic            take;

	assign rf_rs1 = in_dec.rs1;
	assign rf_rs2 = in_dec.rs2;

	always_comb begin
		case (in_dec.v1_src)
			V1_PC:   op_a = in_dec.pc;
			V1_ZIMM: op_a = XLEN'(in_dec.rs1);
			default: op_a = rf_rd1;
		endcase
	end

	assign op_b = (in_dec.v2_src == V2_IMM) ? in_dec.imm : rf_rd2;

	// register values are sampled as the instruction enters the output stage.
	assign in_ready = !out_valid || out_ready;
	assign take     = in_valid && in_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out_pkt <= '{dec: in_dec, op_a: op_a, op_b: op_b};
		end
	end

endmodule

`default_nettype wire

// ==== hdl/pipe_reg.sv ====
`default_nettype none

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  wire           clk,
	input  wire           rst,
	input  wire           in_valid,
	output logic          in_ready,
	input  wire payload_t in_data,
	output logic          out_valid,
	input  wire           out_ready,
	output payload_t      out_data
);

	// a new entry may come in on the same edge that the old one leaves.
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else if (in_ready) begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			out_data <= in_data;
		end
	end

	out_held_stable: assert property (
		@(posedge clk) disable iff (rst)
		out_valid && !out_ready |=> out_valid && $stable(out_data)
	);

endmodule

`default_nettype wire

// ==== hdl/reg_file.sv ====
`default_nettype none

module reg_file
	import rv_isa_pkg::*, fe_pipe_pkg::*;
(
	input  wire             clk,
	input  wire             rst,
	input  wire [4:0]       rs1,
	input  wire [4:0]       rs2,
	output logic [XLEN-1:0] rd1,
	output logic [XLEN-1:0] rd2,
	input  wire rf_write_t  wr
);

	// x0 has no storage and always reads back as zero.
	logic [XLEN-1:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en && wr.addr != 5'd0) begin
			regs[wr.addr] <= wr.data;
		end
	end

	assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hdl/rv_front_end.sv ====
`default_nettype none

module rv_front_end
	import rv_isa_pkg::*, fe_pipe_pkg::*;
#(
	parameter logic [XLEN-1:0] RESET_PC = 64'h1000
) (
	input  wire            clk,
	input  wire            rst,
	output imem_req_t      imem_req,
	input  wire imem_rsp_t imem_rsp,
	input  wire rf_write_t rf_wr,
	output logic           issue_valid,
	input  wire            issue_ready,
	output issue_pkt_t     issue_pkt
);

	redirect_t       redirect;

	logic            f_valid;
	logic            f_ready;
	fetch_pkt_t      f_pkt;

	logic            fd_valid;
	logic            fd_ready;
	fetch_pkt_t      fd_pkt;

	logic            d_valid;
	logic            d_ready;
	decoded_t        d_dec;

	logic            di_valid;
	logic            di_ready;
	decoded_t        di_dec;

	logic [4:0]      rf_rs1;
	logic [4:0]      rf_rs2;
	logic [XLEN-1:0] rf_rd1;
	logic [XLEN-1:0] rf_rd2;

	instr_fetch #(
		.RESET_PC (RESET_PC)
	) u_fetch (
		.clk       (clk),
		.rst       (rst),
		.imem_req  (imem_req),
		.imem_rsp  (imem_rsp),
		.redirect  (redirect),
		.pkt_valid (f_valid),
		.pkt_ready (f_ready),
		.pkt       (f_pkt)
	);

	pipe_reg #(
		.payload_t (fetch_pkt_t)
	) u_fetch_reg (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (f_valid),
		.in_ready  (f_ready),
		.in_data   (f_pkt),
		.out_valid (fd_valid),
		.out_ready (fd_ready),
		.out_data  (fd_pkt)
	);

	instr_decode u_decode (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (fd_valid),
		.in_ready  (fd_ready),
		.in_pkt    (fd_pkt),
		.out_valid (d_valid),
		.out_ready (d_ready),
		.out_dec   (d_dec),
		.redirect  (redirect)
	);

	pipe_reg #(
		.payload_t (decoded_t)
	) u_decode_reg (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (d_valid),
		.in_ready  (d_ready),
		.in_data   (d_dec),
		.out_valid (di_valid),
		.out_ready (di_ready),
		.out_data  (di_dec)
	);

	reg_file u_rf (
		.clk (clk),
		.rst (rst),
		.rs1 (rf_rs1),
		.rs2 (rf_rs2),
		.rd1 (rf_rd1),
		.rd2 (rf_rd2),
		.wr  (rf_wr)
	);

	operand_issue u_issue (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (di_valid),
		.in_ready  (di_ready),
		.in_dec    (di_dec),
		.out_valid (issue_valid),
		.out_ready (issue_ready),
		.out_pkt   (issue_pkt),
		.rf_rs1    (rf_rs1),
		.rf_rs2    (rf_rs2),
		.rf_rd1    (rf_rd1),
		.rf_rd2    (rf_rd2)
	);

endmodule

`default_nettype wire

// ==== hdl/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

	localparam int XLEN = 64;

	// major opcodes found in instr[6:0].
	localparam logic [6:0] OPC_LUI       = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
	localparam logic [6:0] OPC_JAL       = 7'b1101111;
	localparam logic [6:0] OPC_JALR      = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
	localparam logic [6:0] OPC_LOAD      = 7'b0000011;
	localparam logic [6:0] OPC_STORE     = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_OP        = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
	localparam logic [6:0] OPC_OP_32     = 7'b0111011;
	localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;
	localparam logic [6:0] OPC_MISC_MEM  = 7'b0001111;

	// zimm is the rs1 field taken as an unsigned value, as in csrrwi and friends.
	typedef enum logic [1:0] {
		V1_RS1  = 2'd0,
		V1_PC   = 2'd1,
		V1_ZIMM = 2'd2
	} v1_src_t;

	typedef enum logic {
		V2_RS2 = 1'b0,
		V2_IMM = 1'b1
	} v2_src_t;

	typedef enum logic [1:0] {
		MEM_IDLE  = 2'd0,
		MEM_LOAD  = 2'd1,
		MEM_STORE = 2'd2
	} mem_mode_t;

	typedef enum logic [1:0] {
		JMP_IDLE   = 2'd0,
		JMP_JAL    = 2'd1,
		JMP_JALR   = 2'd2,
		JMP_BRANCH = 2'd3
	} jump_mode_t;

	typedef enum logic [1:0] {
		WORD_NONE = 2'd0,
		WORD_IMM  = 2'd1,
		WORD_REG  = 2'd2
	} word_mode_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [6:0]      opcode;
		logic [2:0]      func3;
		logic            func7_b30;
		logic [4:0]      rs1;
		logic [4:0]      rs2;
		logic [4:0]      rd;
		logic [XLEN-1:0] imm;
		v1_src_t         v1_src;
		v2_src_t         v2_src;
		logic            mul_en;
		logic            div_en;
		logic            fence_i;
		word_mode_t      word_mode;
		mem_mode_t       mem_mode;
		jump_mode_t      jump_mode;
	} decoded_t;

endpackage

`default_nettype wire

// ==== rv_front_end.f ====
hdl/rv_isa_pkg.sv
hdl/fe_pipe_pkg.sv
hdl/pipe_reg.sv
hdl/instr_fetch.sv
hdl/instr_decode.sv
hdl/reg_file.sv
hdl/operand_issue.sv
hdl/rv_front_end.sv
verification/rv_front_end_tb.sv

// ==== verification/rv_front_end_tb.sv ====
`default_nettype none

module rv_front_end_tb
	import rv_isa_pkg::*, fe_pipe_pkg::*;
();

	localparam logic [XLEN-1:0] RESET_PC = 64'h1000;
	localparam int PROG_INSTRS = 64;
	localparam int NUM_TESTS = 5;
	localparam int WATCHDOG_CYCLES = 200 * PROG_INSTRS + 50 * NUM_TESTS;

	logic       clk;
	logic       rst;
	imem_req_t  imem_req;
	imem_rsp_t  imem_rsp;
	rf_write_t  rf_wr;
	logic       issue_valid;
	logic       issue_ready;
	issue_pkt_t issue_pkt;

	logic [31:0]     imem [logic [XLEN-1:0]];
	logic [XLEN-1:0] shadow [32];
	logic [XLEN-1:0] exp_pcs [$];
	logic [XLEN-1:0] next_addr;
	logic            mem_on;
	logic            bp_on;
	int              ack_delay;
	logic            wait_ack;
	logic            ack_was;
	logic            req_was_high;
	logic [XLEN-1:0] pend_addr;
	string           cur_test;
	int              errors;
	int              err_at_start;
	int              issued;
	int              tests_run;
	int              tests_failed;
	logic [XLEN-1:0] cmp_pc;
	issue_pkt_t      cmp_exp;

	rv_front_end #(
		.RESET_PC (RESET_PC)
	) UUT (
		.clk         (clk),
		.rst         (rst),
		.imem_req    (imem_req),
		.imem_rsp    (imem_rsp),
		.rf_wr       (rf_wr),
		.issue_valid (issue_valid),
		.issue_ready (issue_ready),
		.issue_pkt   (issue_pkt)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	// the expected issue packet of one instruction takes its operands from the shadow registers.
	function automatic issue_pkt_t expected_issue(input logic [31:0] ins,
		input logic [XLEN-1:0] pc);
		issue_pkt_t e;
		logic [6:0] opc;
		logic [2:0] f3;
		e = '0;
		opc = ins[6:0];
		f3 = ins[14:12];
		e.dec.pc = pc;
		e.dec.opcode = opc;
		e.dec.func3 = f3;
		e.dec.func7_b30 = ins[30];
		e.dec.rs1 = ins[19:15];
		e.dec.rs2 = ins[24:20];
		e.dec.rd = ins[11:7];
		e.dec.v1_src = V1_RS1;
		e.dec.v2_src = V2_IMM;
		case (opc)
			OPC_LUI, OPC_AUIPC: begin
				e.dec.imm = {{32{ins[31]}}, ins[31:12], 12'h000};
				e.dec.rs1 = 5'd0;
				e.dec.rs2 = 5'd0;
				if (opc == OPC_AUIPC) begin
					e.dec.v1_src = V1_PC;
				end
			end
			OPC_JAL: begin
				e.dec.imm = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
				e.dec.v1_src = V1_PC;
				e.dec.jump_mode = JMP_JAL;
			end
			OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_OP_IMM_32, OPC_SYSTEM: begin
				e.dec.imm = {{52{ins[31]}}, ins[31:20]};
				e.dec.rs2 = 5'd0;
				if (opc == OPC_JALR) begin
					e.dec.jump_mode = JMP_JALR;
				end
				if (opc == OPC_LOAD) begin
					e.dec.mem_mode = MEM_LOAD;
				end
				if (opc == OPC_OP_IMM_32) begin
					e.dec.word_mode = WORD_IMM;
				end
				if (opc == OPC_SYSTEM && f3 inside {3'd5, 3'd6, 3'd7}) begin
					e.dec.v1_src = V1_ZIMM;
				end
			end
			OPC_BRANCH: begin
				e.dec.imm = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
				e.dec.rd = 5'd0;
				e.dec.v2_src = V2_RS2;
				e.dec.jump_mode = JMP_BRANCH;
			end
			OPC_STORE: begin
				e.dec.imm = {{52{ins[31]}}, ins[31:25], ins[11:7]};
				e.dec.rd = 5'd0;
				e.dec.mem_mode = MEM_STORE;
			end
			OPC_OP, OPC_OP_32: begin
				e.dec.v2_src = V2_RS2;
				e.dec.mul_en = ins[25] && !f3[2];
				e.dec.div_en = ins[25] && f3[2];
				if (opc == OPC_OP_32) begin
					e.dec.word_mode = WORD_REG;
				end
			end
			default: begin
				e.dec.fence_i = (opc == OPC_MISC_MEM) && f3[0];
			end
		endcase
		case (e.dec.v1_src)
			V1_PC:   e.op_a = pc;
			V1_ZIMM: e.op_a = {59'd0, e.dec.rs1};
			default: e.op_a = shadow[e.dec.rs1];
		endcase
		e.op_b = (e.dec.v2_src == V2_RS2) ? shadow[e.dec.rs2] : e.dec.imm;
		return e;
	endfunction

	task automatic check_value(input string field, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s %s: expected %h, actual %h",
				cur_test, field, expected, actual);
			errors++;
		end
	endtask

	task automatic compare_pkt(input issue_pkt_t e, input issue_pkt_t a);
		check_value("pc", e.dec.pc, a.dec.pc);
		check_value("opcode", 64'(e.dec.opcode), 64'(a.dec.opcode));
		check_value("func3", 64'(e.dec.func3), 64'(a.dec.func3));
		check_value("func7_b30", 64'(e.dec.func7_b30), 64'(a.dec.func7_b30));
		check_value("rs1", 64'(e.dec.rs1), 64'(a.dec.rs1));
		check_value("rs2", 64'(e.dec.rs2), 64'(a.dec.rs2));
		check_value("rd", 64'(e.dec.rd), 64'(a.dec.rd));
		check_value("imm", e.dec.imm, a.dec.imm);
		check_value("v1_src", 64'(e.dec.v1_src), 64'(a.dec.v1_src));
		check_value("v2_src", 64'(e.dec.v2_src), 64'(a.dec.v2_src));
		check_value("mul_en", 64'(e.dec.mul_en), 64'(a.dec.mul_en));
		check_value("div_en", 64'(e.dec.div_en), 64'(a.dec.div_en));
		check_value("fence_i", 64'(e.dec.fence_i), 64'(a.dec.fence_i));
		check_value("word_mode", 64'(e.dec.word_mode), 64'(a.dec.word_mode));
		check_value("mem_mode", 64'(e.dec.mem_mode), 64'(a.dec.mem_mode));
		check_value("jump_mode", 64'(e.dec.jump_mode), 64'(a.dec.jump_mode));
		check_value("op_a", e.op_a, a.op_a);
		check_value("op_b", e.op_b, a.op_b);
	endtask

	task automatic emit(input logic [31:0] ins);
		imem[next_addr] = ins;
		next_addr = next_addr + 64'd4;
	endtask

	// the filler word is addi x31, x31, 1 and must never issue.
	task automatic emit_skips(input int count);
		repeat (count) emit(i_format(12'd1, 5'd31, 3'd0, 5'd31, OPC_OP_IMM));
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [XLEN-1:0] data);
		@(negedge clk);
		rf_wr = '{en: 1'b1, addr: addr, data: data};
		@(negedge clk);
		rf_wr = '0;
		if (addr != 5'd0) begin
			shadow[addr] = data;
		end
	endtask

	task automatic build_expected();
		logic [XLEN-1:0] pc;
		issue_pkt_t e;
		pc = RESET_PC;
		exp_pcs.delete();
		while (imem.exists(pc)) begin
			exp_pcs.push_back(pc);
			e = expected_issue(imem[pc], pc);
			// a jal is followed by its target and never by its fall-through.
			if (e.dec.jump_mode == JMP_JAL) begin
				pc = pc + e.dec.imm;
			end else begin
				pc = pc + 64'd4;
			end
		end
	endtask

	task automatic start_test(input string name);
		@(posedge clk);
		mem_on = 1'b0;
		bp_on = 1'b0;
		@(negedge clk);
		rst = 1'b1;
		cur_test = name;
		err_at_start = errors;
		issued = 0;
		imem.delete();
		exp_pcs.delete();
		for (int i = 0; i < 32; i++) begin
			shadow[i] = '0;
		end
		next_addr = RESET_PC;
		repeat (8) @(negedge clk);
		rst = 1'b0;
	endtask

	task automatic finish_test(input logic with_bp);
		build_expected();
		@(posedge clk);
		mem_on = 1'b1;
		bp_on = with_bp;
		@(negedge clk);
		// done once every packet issued and fetch waits past the program end.
		while (exp_pcs.size() != 0 || !imem_req.req || imem.exists(imem_req.addr)) begin
			@(negedge clk);
		end
		@(posedge clk);
		bp_on = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		tests_run++;
		if (errors == err_at_start) begin
			$display("test %s: ok, %0d packets", cur_test, issued);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors, %0d packets", cur_test, errors - err_at_start, issued);
		end
	endtask

	// fetch must hold req and addr until it sees ack, and may not raise req while ack is high.
	task automatic check_imem_port();
		if (wait_ack && !(imem_req.req && imem_req.addr == pend_addr)) begin
			$display("ERROR %s: fetch dropped req or changed addr before ack", cur_test);
			errors++;
		end
		if (ack_was && !req_was_high && imem_req.req) begin
			$display("ERROR %s: fetch raised req while ack was still high", cur_test);
			errors++;
		end
	endtask

	// this process models the instruction memory and drives issue_ready.
	initial begin
		imem_rsp = '0;
		issue_ready = 1'b0;
		ack_delay = 0;
		wait_ack = 1'b0;
		ack_was = 1'b0;
		req_was_high = 1'b0;
		pend_addr = '0;
		void'($urandom(1));
		forever begin
			@(negedge clk);
			if (mem_on) begin
				check_imem_port();
			end
			if (!mem_on) begin
				imem_rsp = '0;
				ack_delay = $urandom % 4;
			end else if (imem_rsp.ack) begin
				if (!imem_req.req) begin
					imem_rsp.ack = 1'b0;
					ack_delay = $urandom % 4;
				end
			end else if (imem_req.req && imem.exists(imem_req.addr)) begin
				if (ack_delay == 0) begin
					imem_rsp = '{ack: 1'b1, data: imem[imem_req.addr]};
				end else begin
					ack_delay--;
				end
			end
			wait_ack = mem_on && imem_req.req && !imem_rsp.ack;
			ack_was = imem_rsp.ack;
			req_was_high = imem_req.req;
			pend_addr = imem_req.addr;
			issue_ready = bp_on ? 1'($urandom % 2) : 1'b1;
		end
	end

	always @(posedge clk) begin
		if (!rst && issue_valid && issue_ready) begin
			if (exp_pcs.size() == 0) begin
				$display("ERROR %s: packet with pc %h issued after the program had ended",
					cur_test, issue_pkt.dec.pc);
				errors++;
			end else begin
				cmp_pc = exp_pcs.pop_front();
				cmp_exp = expected_issue(imem[cmp_pc], cmp_pc);
				compare_pkt(cmp_exp, issue_pkt);
				issued++;
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: test %s did not finish within %0d cycles", cur_test, WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		rf_wr = '0;
		mem_on = 1'b0;
		bp_on = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;

		start_test("imm_fields");
		emit(i_format(12'hffb, 5'd6, 3'd0, 5'd5, OPC_OP_IMM));
		emit(u_format(20'h80001, 5'd7, OPC_LUI));
		emit(u_format(20'h12345, 5'd3, OPC_AUIPC));
		emit(j_format(21'd16, 5'd1));
		emit_skips(3);
		emit(b_format(13'h1ff8, 5'd2, 5'd1, 3'd0));
		emit(s_format(12'hfec, 5'd9, 5'd10, 3'd3));
		emit(r_format(7'h20, 5'd13, 5'd12, 3'd0, 5'd11, OPC_OP));
		finish_test(1'b0);

		start_test("operand_select");
		write_reg(5'd5, 64'h1111_2222_3333_4444);
		write_reg(5'd6, 64'hffff_ffff_ffff_fff0);
		write_reg(5'd31, 64'h0123_4567_89ab_cdef);
		write_reg(5'd0, 64'hdead_beef_dead_beef);
		emit(r_format(7'h00, 5'd6, 5'd5, 3'd0, 5'd1, OPC_OP));
		emit(i_format(12'd100, 5'd6, 3'd0, 5'd2, OPC_OP_IMM));
		emit(u_format(20'h00001, 5'd3, OPC_AUIPC));
		emit(i_format(12'h300, 5'd17, 3'd5, 5'd4, OPC_SYSTEM));
		emit(i_format(12'h301, 5'd5, 3'd2, 5'd8, OPC_SYSTEM));
		emit(r_format(7'h00, 5'd31, 5'd0, 3'd0, 5'd9, OPC_OP));
		emit(s_format(12'd8, 5'd6, 5'd5, 3'd2));
		emit(b_format(13'd32, 5'd31, 5'd5, 3'd0));
		finish_test(1'b0);

		start_test("special_flags");
		write_reg(5'd2, 64'h0000_0000_0000_0007);
		write_reg(5'd3, 64'h8000_0000_0000_0003);
		write_reg(5'd5, 64'h0000_00ff_0000_0100);
		write_reg(5'd6, 64'hffff_ffff_ffff_fffe);
		emit(r_format(7'h01, 5'd3, 5'd2, 3'd0, 5'd1, OPC_OP));
		emit(r_format(7'h01, 5'd6, 5'd5, 3'd5, 5'd4, OPC_OP));
		emit(r_format(7'h01, 5'd3, 5'd2, 3'd6, 5'd7, OPC_OP_32));
		emit(r_format(7'h00, 5'd6, 5'd5, 3'd0, 5'd10, OPC_OP_32));
		emit(i_format(12'hfff, 5'd2, 3'd0, 5'd13, OPC_OP_IMM_32));
		emit(i_format(12'h000, 5'd0, 3'd1, 5'd0, OPC_MISC_MEM));
		emit(i_format(12'h0ff, 5'd0, 3'd0, 5'd0, OPC_MISC_MEM));
		emit(i_format(12'd16, 5'd3, 3'd3, 5'd15, OPC_LOAD));
		emit(s_format(12'hfff, 5'd5, 5'd6, 3'd0));
		emit(i_format(12'd4, 5'd2, 3'd0, 5'd1, OPC_JALR));
		finish_test(1'b0);

		start_test("jal_redirect");
		emit(i_format(12'd1, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
		emit(j_format(21'd12, 5'd0));
		emit_skips(2);
		emit(j_format(21'd8, 5'd1));
		emit_skips(1);
		emit(j_format(21'd24, 5'd5));
		emit_skips(5);
		emit(i_format(12'd6, 5'd0, 3'd0, 5'd6, OPC_OP_IMM));
		emit(j_format(21'd8, 5'd0));
		emit_skips(1);
		emit(i_format(12'd7, 5'd0, 3'd0, 5'd7, OPC_OP_IMM));
		finish_test(1'b0);

		start_test("back_pressure");
		for (int i = 1; i < 8; i++) begin
			write_reg(5'(i), 64'(i) * 64'h0101_0101_0101_0101);
		end
		for (int i = 0; i < 20; i++) begin
			if (i == 9) begin
				emit(j_format(21'd12, 5'd1));
			end else if (i == 15) begin
				emit(j_format(21'd8, 5'd0));
			end else if (i % 3 == 0) begin
				emit(r_format(7'h00, 5'(i % 8), 5'(i % 5 + 1), 3'd0, 5'(i + 1), OPC_OP));
			end else begin
				emit(i_format(12'(i * 3), 5'(i % 7), 3'd0, 5'(i + 1), OPC_OP_IMM));
			end
		end
		finish_test(1'b1);

		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
